// File: filelist.f
+incdir+logic
logic/sys1_pkg.sv
logic/rom_loader.sv
logic/key_decoder.sv
logic/control_mapper.sv
logic/sys1_io_top.sv
bench/sys1_asserts.sv
bench/sys1_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = sys1_tb
FILELIST = filelist.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
SIMFLAGS = +verilator+error+limit+1000
LOG = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST)) logic/sys1_defines.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/sys1_tb.sv
/*
 Testbench for the System-1 control and loader top level.
 Stimulus only; the bound assertions do the checking.
 Inputs change 2 time units after each rising clock edge.
*/
`include "sys1_defines.svh"

module sys1_tb;
	import sys1_pkg::*;

	localparam int wait_limit = 16;

	logic clk_sys;
	logic reset;
	logic load_active;
	logic load_wr;
	logic [7:0] load_index;
	logic [24:0] load_addr;
	logic [7:0] load_data;
	logic [10:0] key_event;
	logic [2:0] mouse_buttons;
	logic mouse_swap;
	logic [31:0] joystick;
	logic [15:0] analog_left;
	logic [15:0] analog_right;
	logic [2:0] adc_addr;
	logic gfx_we;
	logic [21:0] gfx_addr;
	logic [63:0] gfx_data;
	logic rom_we;
	load_region_e rom_region;
	logic [14:0] rom_addr;
	logic [15:0] rom_data;
	game_type_e game_type;
	logic [7:0] board_inputs;
	logic [4:0] board_switches;
	logic [7:0] adc_data;
	logic wheel_mode;
	logic [2:0] coin_n;
	logic [15:0] analog_wheel;

	integer seed;
	int tb_errors;
	int total_errors;

	sys1_io_top dut (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Backstop in case a wait loop itself misbehaves
	initial
	begin
		#400000;
		$display("Watchdog expired before the stimulus finished");
		$display("Simulation failed");
		$finish;
	end

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	function automatic logic [7:0] rand_byte();
		integer r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic report_timeout(input string what);
		tb_errors++;
		$display("Timeout at time %0t while waiting for %s", $time, what);
	endtask

	task automatic write_byte(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		load_wr = 1'b1;
		load_index = index;
		load_addr = addr;
		load_data = data;
		step();
	endtask

	task automatic end_write();
		load_wr = 1'b0;
		load_index = 8'd0;
	endtask

	task automatic wait_rom_strobe();
		int n;
		n = 0;
		while (!rom_we && n < wait_limit)
		begin
			step();
			n++;
		end
		if (!rom_we)
			report_timeout("ROM write strobe");
		step();
	endtask

	task automatic write_pair(input logic [24:0] base);
		write_byte(8'd0, {base[24:1], 1'b0}, rand_byte());
		write_byte(8'd0, {base[24:1], 1'b1}, rand_byte());
		end_write();
		wait_rom_strobe();
	endtask

	task automatic write_single(input logic [24:0] addr);
		write_byte(8'd0, addr, rand_byte());
		end_write();
		wait_rom_strobe();
	endtask

	// Toggle bit 10 to flag a new event
	task automatic send_key(input logic [8:0] code, input logic pressed);
		key_event = {~key_event[10], pressed, code};
		step();
	endtask

	task automatic wait_indy_up(input logic level);
		int n;
		n = 0;
		while (board_inputs[4] != level && n < wait_limit)
		begin
			step();
			n++;
		end
		if (board_inputs[4] != level)
			report_timeout("up key on board inputs");
	endtask

	task automatic wait_coin(input logic level_n);
		int n;
		n = 0;
		while (coin_n[0] != level_n && n < wait_limit)
		begin
			step();
			n++;
		end
		if (coin_n[0] != level_n)
			report_timeout("left coin level");
	endtask

	task automatic select_game(input game_type_e game);
		int n;
		write_byte(8'd1, 25'd0, 8'(game));
		end_write();
		n = 0;
		while (game_type != game && n < wait_limit)
		begin
			step();
			n++;
		end
		if (game_type != game)
			report_timeout("game type load");
	endtask

	// Every ADC channel with fresh stick, buttons and mouse values
	task automatic sweep_controls(input int rounds);
		for (int i = 0; i < rounds; i++)
		begin
			adc_addr = 3'(i);
			joystick = {24'd0, rand_byte() & 8'h3F};
			analog_left = {rand_byte(), rand_byte()};
			analog_right = {rand_byte(), rand_byte()};
			mouse_buttons = 3'(rand_byte());
			mouse_swap = rand_byte() < 8'h80;
			step();
		end
		joystick = 32'd0;
		step();
		step();
	endtask

	initial
	begin
		seed = 32'h97bfd3d3;
		tb_errors = 0;
		reset = 1'b1;
		load_active = 1'b0;
		load_wr = 1'b0;
		load_index = 8'd0;
		load_addr = '0;
		load_data = 8'd0;
		key_event = '0;
		mouse_buttons = 3'd0;
		mouse_swap = 1'b0;
		joystick = 32'd0;
		analog_left = 16'd0;
		analog_right = 16'd0;
		adc_addr = 3'd0;
		repeat (8) step();
		reset = 1'b0;
		repeat (4) step();

		// ####################
		// Graphics run, bank 2, planes 0 to 7
		load_active = 1'b1;
		for (int p = 0; p < 8; p++)
			write_byte(8'd0, {3'd0, 3'd2, 16'h5A3C, 3'(p)}, rand_byte());
		end_write();
		if (!gfx_we)
			report_timeout("graphics write strobe");
		step();

		// Program pairs and byte regions
		write_pair({`SYS1_RGN_ROM1, 16'h1A2C});
		write_pair({`SYS1_RGN_ROM7, 16'h0456});
		write_pair({`SYS1_RGN_SLAP, 15'h2310});
		write_single({`SYS1_RGN_SROM2, 14'h0155});
		write_single({`SYS1_RGN_COLOR, 9'h0A3});
		write_single({`SYS1_RGN_EEPROM, 9'h1FE});

		// Writes that must not strobe
		write_byte(8'd0, 25'h1FF_FFFF, rand_byte());
		write_byte(8'd2, {`SYS1_RGN_ROM1, 16'h0001}, rand_byte());
		load_active = 1'b0;
		write_byte(8'd0, {`SYS1_RGN_ROM1, 16'h0003}, rand_byte());
		end_write();
		repeat (3) step();

		// ####################
		// Keys on the default Indy layout
		send_key(9'h175, 1'b1);
		wait_indy_up(1'b1);
		// Release word with the old toggle bit, must be ignored
		key_event = {key_event[10], 1'b0, key_event[8:0]};
		repeat (4) step();
		send_key(9'h014, 1'b1);
		send_key(9'h02E, 1'b1);
		wait_coin(1'b0);
		send_key(9'h175, 1'b0);
		wait_indy_up(1'b0);
		send_key(9'h014, 1'b0);
		send_key(9'h02E, 1'b0);
		wait_coin(1'b1);
		repeat (3) step();

		// ####################
		// Each game in turn
		sweep_controls(16);
		select_game(game_peterpak);
		sweep_controls(16);
		select_game(game_roadrunn);
		sweep_controls(16);
		select_game(game_roadb109);
		sweep_controls(24);
		// Variant load while a download runs
		load_active = 1'b1;
		select_game(game_roadb110);
		load_active = 1'b0;
		sweep_controls(16);
		select_game(game_marble);
		sweep_controls(24);
		select_game(game_indy);
		sweep_controls(8);
		repeat (4) step();

		total_errors = tb_errors + dut.u_asserts.fail_count;
		$display("Error counts: %0d assertion failures, %0d testbench errors",
			dut.u_asserts.fail_count, tb_errors);
		if (total_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: bench/sys1_asserts.sv
/*
 Concurrent checks on the System-1 control and loader ports.
 Bound into sys1_io_top; failures raise $error and bump fail_count.
 Payload checks expect program pairs and graphics runs written back to back.
 Control checks expect all keyboard keys released during game sweeps.
*/
`include "sys1_defines.svh"

module sys1_asserts (
	input logic clk_sys,
	input logic reset,
	input logic load_active,
	input logic load_wr,
	input logic [7:0] load_index,
	input logic [`SYS1_LOAD_AW-1:0] load_addr,
	input logic [7:0] load_data,
	input logic [10:0] key_event,
	input logic [2:0] mouse_buttons,
	input logic mouse_swap,
	input logic [31:0] joystick,
	input logic [15:0] analog_left,
	input logic [15:0] analog_right,
	input logic [2:0] adc_addr,
	input logic gfx_we,
	input logic [`SYS1_GFX_AW-1:0] gfx_addr,
	input logic [63:0] gfx_data,
	input logic rom_we,
	input sys1_pkg::load_region_e rom_region,
	input logic [`SYS1_PROG_AW-1:0] rom_addr,
	input logic [15:0] rom_data,
	input sys1_pkg::game_type_e game_type,
	input logic [7:0] board_inputs,
	input logic [4:0] board_switches,
	input logic [7:0] adc_data,
	input logic wheel_mode,
	input logic [2:0] coin_n,
	input logic [15:0] analog_wheel
);
	import sys1_pkg::*;

	int fail_count = 0;
	logic accepted;
	logic gfx_last;

	assign accepted = load_wr && load_active && (load_index == 8'd0);
	// Plane 7 of area 0 closes a graphics word
	assign gfx_last = (load_addr[24:22] == 3'd0) && (load_addr[2:0] == 3'd7);

	// Region table, matched on the upper address bits
	function automatic load_region_e expect_region(input logic [24:0] a);
		if (a[24:22] == 3'd0)
			return rgn_gfx;
		if (a[24:15] == `SYS1_RGN_ROM0)
			return rgn_rom0;
		if (a[24:16] == `SYS1_RGN_ROM1)
			return rgn_rom1;
		if (a[24:16] == `SYS1_RGN_ROM2)
			return rgn_rom2;
		if (a[24:16] == `SYS1_RGN_ROM5)
			return rgn_rom5;
		if (a[24:16] == `SYS1_RGN_ROM6)
			return rgn_rom6;
		if (a[24:16] == `SYS1_RGN_ROM7)
			return rgn_rom7;
		if (a[24:15] == `SYS1_RGN_SLAP)
			return rgn_slap;
		if (a[24:14] == `SYS1_RGN_SROM0)
			return rgn_srom0;
		if (a[24:14] == `SYS1_RGN_SROM1)
			return rgn_srom1;
		if (a[24:14] == `SYS1_RGN_SROM2)
			return rgn_srom2;
		if (a[24:14] == `SYS1_RGN_ALPHA)
			return rgn_alpha;
		if (a[24:9] == `SYS1_RGN_COLOR)
			return rgn_color;
		if (a[24:9] == `SYS1_RGN_REMAP)
			return rgn_remap;
		if (a[24:9] == `SYS1_RGN_EEPROM)
			return rgn_eeprom;
		return rgn_none;
	endfunction

	function automatic logic is_prog(input load_region_e r);
		return r inside {rgn_rom0, rgn_rom1, rgn_rom2, rgn_rom5, rgn_rom6, rgn_rom7, rgn_slap};
	endfunction

	function automatic logic is_byte(input load_region_e r);
		return r inside {rgn_srom0, rgn_srom1, rgn_srom2, rgn_alpha, rgn_color, rgn_remap,
			rgn_eeprom};
	endfunction

	// Odd byte of a program pair, or any byte of a byte region
	function automatic logic rom_expected(input logic [24:0] a);
		return (is_prog(expect_region(a)) && a[0]) || is_byte(expect_region(a));
	endfunction

	function automatic logic [14:0] expect_addr(input logic [24:0] a);
		case (expect_region(a))
			rgn_rom0, rgn_slap: return {1'b0, a[14:1]};
			rgn_rom1, rgn_rom2, rgn_rom5, rgn_rom6, rgn_rom7: return a[15:1];
			rgn_srom0, rgn_srom1, rgn_srom2, rgn_alpha: return {1'b0, a[13:0]};
			default: return {6'd0, a[8:0]};
		endcase
	endfunction

	// Indy stick directions land on ADC channels 1 to 4
	function automatic logic indy_dir_on(input logic [3:0] dirs, input logic [2:0] chan);
		case (chan)
			3'd1: return dirs[0];
			3'd2: return dirs[1];
			3'd3: return dirs[2];
			3'd4: return dirs[3];
			default: return 1'b0;
		endcase
	endfunction

	// Stick turned 45 degrees, each direction joins its clockwise neighbour
	function automatic logic [3:0] rotate_dirs(input logic [3:0] d);
		logic up;
		logic down;
		logic left;
		logic right;
		up = d[3];
		down = d[2];
		left = d[1];
		right = d[0];
		return {up | right, down | left, left | up, right | down};
	endfunction

	// ####################
	// Reset and loader

	a_reset_state: assert property (@(posedge clk_sys) $past(reset) |->
		!gfx_we && !rom_we && game_type == game_indy && coin_n == 3'b111 && !wheel_mode
		&& adc_data == `SYS1_ADC_CENTER)
	else
	begin
		fail_count++;
		$error("mismatch at %0t: outputs not in reset state", $time);
	end

	a_gfx_cause: assert property (@(posedge clk_sys) disable iff (reset)
		gfx_we |-> $past(accepted && gfx_last))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: graphics strobe without plane 7 write", $time);
	end

	a_gfx_made: assert property (@(posedge clk_sys) disable iff (reset)
		accepted && gfx_last |=> gfx_we)
	else
	begin
		fail_count++;
		$error("mismatch at %0t: plane 7 write gave no graphics strobe", $time);
	end

	a_gfx_payload: assert property (@(posedge clk_sys) disable iff (reset)
		gfx_we |-> gfx_addr == $past(load_addr[24:3]) && gfx_data == {$past(load_data, 8),
		$past(load_data, 7), $past(load_data, 6), $past(load_data, 5), $past(load_data, 4),
		$past(load_data, 3), $past(load_data, 2), $past(load_data, 1)})
	else
	begin
		fail_count++;
		$error("mismatch at %0t: graphics word address or data", $time);
	end

	a_rom_cause: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we |-> $past(accepted && rom_expected(load_addr)))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: ROM strobe without matching write", $time);
	end

	a_rom_made: assert property (@(posedge clk_sys) disable iff (reset)
		accepted && rom_expected(load_addr) |=> rom_we)
	else
	begin
		fail_count++;
		$error("mismatch at %0t: ROM write gave no strobe", $time);
	end

	a_rom_target: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we |-> rom_region == expect_region($past(load_addr))
		&& rom_addr == expect_addr($past(load_addr)))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: ROM region or address", $time);
	end

	a_rom_payload: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we |-> rom_data == (is_prog(rom_region) ?
		{$past(load_data, 2), $past(load_data, 1)} : {8'h00, $past(load_data, 1)}))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: ROM data", $time);
	end

	// ####################
	// Keys and game variant

	a_game_load: assert property (@(posedge clk_sys) disable iff (reset)
		$past(load_wr && load_index == 8'd1) |-> game_type == $past(load_data))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: game type not loaded", $time);
	end

	// Up arrow reaches Indy board input 4 after decode and mapping
	a_key_up: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(key_event[10]) && key_event[8:0] == 9'h175 && game_type == game_indy
		&& joystick[3:0] == 4'd0 ##0 1'b1 |-> ##2 board_inputs[4] == $past(key_event[9], 2))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: up key level on board inputs", $time);
	end

	a_key_repeat: assert property (@(posedge clk_sys) disable iff (reset)
		!$changed(key_event[10]) && game_type == game_indy && joystick == 32'd0
		##1 game_type == game_indy && joystick == 32'd0 |=> $stable(board_inputs))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: board inputs moved without a key event", $time);
	end

	a_coin_key: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(key_event[10]) && key_event[8:0] == 9'h02E && !joystick[8] |->
		##2 ($past(load_active) || coin_n[0] == !$past(key_event[9], 2)))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: left coin level", $time);
	end

	// ####################
	// Per-game mapping

	a_indy_adc: assert property (@(posedge clk_sys) disable iff (reset)
		$past(game_type) == game_indy |-> adc_data ==
		(indy_dir_on($past(joystick[3:0]), $past(adc_addr)) ? `SYS1_ADC_FULL
		: `SYS1_ADC_CENTER))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: Indy ADC value", $time);
	end

	a_peterpak_sw: assert property (@(posedge clk_sys) disable iff (reset)
		$past(game_type) == game_peterpak |-> board_switches ==
		{2'b11, !$past(joystick[4]), 1'b1, !$past(joystick[5])})
	else
	begin
		fail_count++;
		$error("mismatch at %0t: Peterpak switches", $time);
	end

	a_roadrunn_adc: assert property (@(posedge clk_sys) disable iff (reset)
		$past(game_type) == game_roadrunn |-> adc_data ==
		(($past(adc_addr) == 3'd0) ? ($past(analog_left[7:0]) ^ `SYS1_ADC_INV_SIGNED) :
		($past(adc_addr) == 3'd7) ? ($past(analog_left[15:8]) ^ `SYS1_ADC_CENTER) :
		`SYS1_ADC_CENTER))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: Road Runner ADC value", $time);
	end

	a_roadb_wheel: assert property (@(posedge clk_sys) disable iff (reset)
		$past(game_type) inside {game_roadb109, game_roadb110} |-> wheel_mode
		&& analog_wheel == {$past(analog_right[15:8]), $past(analog_left[7:0])})
	else
	begin
		fail_count++;
		$error("mismatch at %0t: wheel mode or wheel position", $time);
	end

	// Idle throttle reads zero, pushed stick reads nonzero unless at the end stop
	a_roadb_throttle: assert property (@(posedge clk_sys) disable iff (reset)
		$past(game_type) inside {game_roadb109, game_roadb110} |->
		(($past(adc_addr) == 3'd3 && $past(analog_left[15])) ?
		($past(analog_left[15:8]) == 8'hFF || adc_data != 8'h00) : adc_data == 8'h00))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: throttle outside negative Y", $time);
	end

	a_wheel_off: assert property (@(posedge clk_sys) disable iff (reset)
		!($past(game_type) inside {game_roadb109, game_roadb110}) |-> !wheel_mode)
	else
	begin
		fail_count++;
		$error("mismatch at %0t: wheel mode outside Roadblasters", $time);
	end

	a_marble_dirs: assert property (@(posedge clk_sys) disable iff (reset)
		$past(game_type) == game_marble |-> board_inputs ==
		{4'd0, rotate_dirs($past(joystick[3:0]))})
	else
	begin
		fail_count++;
		$error("mismatch at %0t: Marble rotated directions", $time);
	end

	// Mouse buttons two samples back, crossed unless swapped
	a_marble_mouse: assert property (@(posedge clk_sys) disable iff (reset)
		$past(game_type) == game_marble && !$past(reset, 2) |-> board_switches ==
		{3'b111,
		!($past(joystick[4]) | ($past(mouse_swap, 2) ? $past(mouse_buttons[0], 2)
		: $past(mouse_buttons[1], 2))),
		!($past(joystick[5]) | ($past(mouse_swap, 2) ? $past(mouse_buttons[1], 2)
		: $past(mouse_buttons[0], 2)))})
	else
	begin
		fail_count++;
		$error("mismatch at %0t: Marble mouse switches", $time);
	end

endmodule

bind sys1_io_top sys1_asserts u_asserts (.*);

// File: logic/sys1_io_top.sv
/*
 Control and ROM-loading side of the System-1 wrapper.
 Ends at the store write strobes and the board input levels.
 Single clock, synchronous active-high reset.
*/
`include "sys1_defines.svh"

module sys1_io_top (
	input logic clk_sys,
	input logic reset,
	// Download stream
	input logic load_active,
	input logic load_wr,
	input logic [7:0] load_index,
	input logic [`SYS1_LOAD_AW-1:0] load_addr,
	input logic [7:0] load_data,
	// Player controls
	input logic [10:0] key_event,
	input logic [2:0] mouse_buttons,
	input logic mouse_swap,
	input logic [31:0] joystick,
	input logic [15:0] analog_left,
	input logic [15:0] analog_right,
	input logic [2:0] adc_addr,
	// Store writes
	output logic gfx_we,
	output logic [`SYS1_GFX_AW-1:0] gfx_addr,
	output logic [63:0] gfx_data,
	output logic rom_we,
	output sys1_pkg::load_region_e rom_region,
	output logic [`SYS1_PROG_AW-1:0] rom_addr,
	output logic [15:0] rom_data,
	// Board side
	output sys1_pkg::game_type_e game_type,
	output logic [7:0] board_inputs,
	output logic [4:0] board_switches,
	output logic [7:0] adc_data,
	output logic wheel_mode,
	output logic [2:0] coin_n,
	output logic [15:0] analog_wheel
);

	logic [5:0] p1_keys;
	logic [2:0] coin_keys;

	rom_loader u_loader (
		.clk_sys(clk_sys),
		.reset(reset),
		.load_active(load_active),
		.load_wr(load_wr),
		.load_index(load_index),
		.load_addr(load_addr),
		.load_data(load_data),
		.gfx_we(gfx_we),
		.gfx_addr(gfx_addr),
		.gfx_data(gfx_data),
		.rom_we(rom_we),
		.rom_region(rom_region),
		.rom_addr(rom_addr),
		.rom_data(rom_data)
	);

	key_decoder u_keys (
		.clk_sys(clk_sys),
		.reset(reset),
		.key_event(key_event),
		.p1_keys(p1_keys),
		.coin_keys(coin_keys)
	);

	// Watches index 1 on the same download bus
	control_mapper u_controls (
		.clk_sys(clk_sys),
		.reset(reset),
		.load_active(load_active),
		.load_wr(load_wr),
		.load_index(load_index),
		.load_data(load_data),
		.p1_keys(p1_keys),
		.coin_keys(coin_keys),
		.joystick(joystick),
		.mouse_buttons(mouse_buttons),
		.mouse_swap(mouse_swap),
		.analog_left(analog_left),
		.analog_right(analog_right),
		.adc_addr(adc_addr),
		.game_type(game_type),
		.board_inputs(board_inputs),
		.board_switches(board_switches),
		.adc_data(adc_data),
		.wheel_mode(wheel_mode),
		.coin_n(coin_n),
		.analog_wheel(analog_wheel)
	);

endmodule

// File: logic/control_mapper.sv
/*
 Game variant register and player control mapping for the board inputs.
 Index 1 writes load the variant whether or not a download is active.
 Outputs are registered; the mouse path has one extra register stage.
 Coins are held inactive while a download runs.
 Unknown variants fall back to the plain joystick layout.
*/
`include "sys1_defines.svh"

module control_mapper (
	input logic clk_sys,
	input logic reset,
	input logic load_active,
	input logic load_wr,
	input logic [7:0] load_index,
	input logic [7:0] load_data,
	input logic [5:0] p1_keys,
	input logic [2:0] coin_keys,
	input logic [31:0] joystick,
	input logic [2:0] mouse_buttons,
	input logic mouse_swap,
	input logic [15:0] analog_left,
	input logic [15:0] analog_right,
	input logic [2:0] adc_addr,
	output sys1_pkg::game_type_e game_type,
	output logic [7:0] board_inputs,
	output logic [4:0] board_switches,
	output logic [7:0] adc_data,
	output logic wheel_mode,
	output logic [2:0] coin_n,
	output logic [15:0] analog_wheel
);
	import sys1_pkg::*;

	logic mouse_l;
	logic mouse_r;
	logic [3:0] dir_any;
	logic jump_any;
	logic start_any;
	logic [7:0] plain_inputs;
	logic [7:0] indy_inputs;
	logic [4:0] mouse_switches;
	logic [7:0] inputs_nx;
	logic [4:0] switches_nx;
	logic [7:0] adc_nx;
	logic wheel_nx;
	logic [15:0] wheel_pos_nx;

	// ####################
	// Variant register
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			game_type <= game_type_e'(`SYS1_GAME_DEFAULT);
		else if (load_wr && (load_index == 8'd1))
			game_type <= game_type_e'(load_data);
	end

	// Board buttons sit crossed against the mouse unless swapped
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			mouse_l <= 1'b0;
			mouse_r <= 1'b0;
		end
		else
		begin
			mouse_l <= mouse_swap ? mouse_buttons[0] : mouse_buttons[1];
			mouse_r <= mouse_swap ? mouse_buttons[1] : mouse_buttons[0];
		end
	end

	// Keys and stick merged, UDLR order
	assign dir_any = p1_keys[5:2] | joystick[3:0];
	assign jump_any = p1_keys[0] | joystick[4];
	assign start_any = p1_keys[1] | joystick[5];
	assign plain_inputs = {4'b0000, dir_any};
	// Indy reads directions one place up
	assign indy_inputs = {3'b000, dir_any, 1'b0};
	assign mouse_switches = {3'b111, ~(jump_any | mouse_l), ~(start_any | mouse_r)};

	// ####################
	// Per-variant layout
	always_comb
	begin
		inputs_nx = plain_inputs;
		switches_nx = {3'b111, ~jump_any, ~start_any};
		adc_nx = `SYS1_ADC_CENTER;
		wheel_nx = 1'b0;
		wheel_pos_nx = '0;
		case (game_type)
			game_marble:
			begin
				// Trackball mounted 45 degrees clockwise
				inputs_nx = {4'b0000, dir_any[3] | dir_any[0], dir_any[2] | dir_any[1],
					dir_any[1] | dir_any[3], dir_any[0] | dir_any[2]};
				switches_nx = mouse_switches;
			end
			game_indy:
			begin
				inputs_nx = indy_inputs;
				// On/off stick through the ADC
				adc_nx = indy_inputs[adc_addr] ? `SYS1_ADC_FULL : `SYS1_ADC_CENTER;
			end
			game_peterpak:
			begin
				// NC NC jump NC throw
				switches_nx = {2'b11, ~jump_any, 1'b1, ~start_any};
				adc_nx = plain_inputs[adc_addr] ? `SYS1_ADC_FULL : `SYS1_ADC_CENTER;
			end
			game_roadrunn:
			begin
				// Signed stick to unsigned, X also inverted
				if (adc_addr == 3'd0)
					adc_nx = analog_left[7:0] ^ `SYS1_ADC_INV_SIGNED;
				else if (adc_addr == 3'd7)
					adc_nx = analog_left[15:8] ^ `SYS1_ADC_CENTER;
			end
			game_roadb109, game_roadb110:
			begin
				wheel_nx = 1'b1;
				inputs_nx = {4'b0000, joystick[0], joystick[1], joystick[2], joystick[3]};
				switches_nx = mouse_switches;
				// Throttle from the upper half of the stick only
				if ((adc_addr == 3'd3) && analog_left[15])
					adc_nx = {analog_left[14:8], 1'b1} ^ `SYS1_ADC_FULL;
				else
					adc_nx = 8'h00;
				wheel_pos_nx = {analog_right[15:8], analog_left[7:0]};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			board_inputs <= '0;
			board_switches <= '1;
			adc_data <= `SYS1_ADC_CENTER;
			wheel_mode <= 1'b0;
			analog_wheel <= '0;
			coin_n <= '1;
		end
		else
		begin
			board_inputs <= inputs_nx;
			board_switches <= switches_nx;
			adc_data <= adc_nx;
			wheel_mode <= wheel_nx;
			analog_wheel <= wheel_pos_nx;
			// Aux, right, left; stick coin joins the left slot
			coin_n <= load_active ? 3'b111 :
				~{coin_keys[2], coin_keys[1], coin_keys[0] | joystick[8]};
		end
	end

endmodule

// File: logic/key_decoder.sv
/*
 Keyboard scan events to held key levels for player 1 and the coins.
 A new event is flagged by bit 10 changing; bit 9 is the pressed flag.
 Codes are the extended set-2 values, extended keys with bit 8 set.
*/
module key_decoder (
	input logic clk_sys,
	input logic reset,
	input logic [10:0] key_event,
	output logic [5:0] p1_keys,
	output logic [2:0] coin_keys
);

	// MAME default layout
	localparam logic [8:0] key_up = 9'h175;
	localparam logic [8:0] key_down = 9'h172;
	localparam logic [8:0] key_left = 9'h16B;
	localparam logic [8:0] key_right = 9'h174;
	localparam logic [8:0] key_lctrl = 9'h014;
	localparam logic [8:0] key_lalt = 9'h011;
	localparam logic [8:0] key_5 = 9'h02E;
	localparam logic [8:0] key_6 = 9'h036;
	localparam logic [8:0] key_7 = 9'h03D;

	logic toggle_q;
	logic pressed;

	assign pressed = key_event[9];

	always_ff @(posedge clk_sys)
	begin
		// Follow the toggle during reset so no stale event fires after it
		toggle_q <= key_event[10];
		if (reset)
		begin
			p1_keys <= '0;
			coin_keys <= '0;
		end
		else if (key_event[10] != toggle_q)
		begin
			case (key_event[8:0])
				key_up: p1_keys[5] <= pressed;
				key_down: p1_keys[4] <= pressed;
				key_left: p1_keys[3] <= pressed;
				key_right: p1_keys[2] <= pressed;
				// Start or whip
				key_lctrl: p1_keys[1] <= pressed;
				key_lalt: p1_keys[0] <= pressed;
				// Coins left, right, aux
				key_5: coin_keys[0] <= pressed;
				key_6: coin_keys[1] <= pressed;
				key_7: coin_keys[2] <= pressed;
				default: ;
			endcase
		end
	end

endmodule

// File: logic/rom_loader.sv
/*
 Turns the download byte stream into write strobes for the ROM stores.
 Only index 0 writes while the download flag is high are accepted.
 All outputs are registered, one cycle after the accepted byte.
 No back-pressure; the stores must take a write every cycle.
 The byte accumulator keeps running across region boundaries.
*/
`include "sys1_defines.svh"

module rom_loader (
	input logic clk_sys,
	input logic reset,
	input logic load_active,
	input logic load_wr,
	input logic [7:0] load_index,
	input sys1_pkg::load_addr_u load_addr,
	input logic [7:0] load_data,
	output logic gfx_we,
	output logic [`SYS1_GFX_AW-1:0] gfx_addr,
	output logic [63:0] gfx_data,
	output logic rom_we,
	output sys1_pkg::load_region_e rom_region,
	output logic [`SYS1_PROG_AW-1:0] rom_addr,
	output logic [15:0] rom_data
);
	import sys1_pkg::*;

	logic accepted;
	logic [55:0] acc_bytes;
	load_region_e region_sel;
	logic prog_sel;
	logic byte_sel;
	logic gfx_hit;
	logic rom_hit;
	logic [`SYS1_PROG_AW-1:0] rom_addr_nx;

	assign accepted = load_wr && load_active && (load_index == 8'd0);

	// Region table
	always_comb
	begin
		region_sel = rgn_none;
		if (load_addr.gfx.area == 3'd0)
			region_sel = rgn_gfx;
		else if (load_addr.rom.word[23:14] == `SYS1_RGN_ROM0)
			region_sel = rgn_rom0;
		else if (load_addr.rom.word[23:15] == `SYS1_RGN_ROM1)
			region_sel = rgn_rom1;
		else if (load_addr.rom.word[23:15] == `SYS1_RGN_ROM2)
			region_sel = rgn_rom2;
		else if (load_addr.rom.word[23:15] == `SYS1_RGN_ROM5)
			region_sel = rgn_rom5;
		else if (load_addr.rom.word[23:15] == `SYS1_RGN_ROM6)
			region_sel = rgn_rom6;
		else if (load_addr.rom.word[23:15] == `SYS1_RGN_ROM7)
			region_sel = rgn_rom7;
		else if (load_addr.rom.word[23:14] == `SYS1_RGN_SLAP)
			region_sel = rgn_slap;
		else if (load_addr[24:14] == `SYS1_RGN_SROM0)
			region_sel = rgn_srom0;
		else if (load_addr[24:14] == `SYS1_RGN_SROM1)
			region_sel = rgn_srom1;
		else if (load_addr[24:14] == `SYS1_RGN_SROM2)
			region_sel = rgn_srom2;
		else if (load_addr[24:14] == `SYS1_RGN_ALPHA)
			region_sel = rgn_alpha;
		else if (load_addr[24:9] == `SYS1_RGN_COLOR)
			region_sel = rgn_color;
		else if (load_addr[24:9] == `SYS1_RGN_REMAP)
			region_sel = rgn_remap;
		else if (load_addr[24:9] == `SYS1_RGN_EEPROM)
			region_sel = rgn_eeprom;
	end

	assign prog_sel = region_sel inside {rgn_rom0, rgn_rom1, rgn_rom2, rgn_rom5,
		rgn_rom6, rgn_rom7, rgn_slap};
	assign byte_sel = region_sel inside {rgn_srom0, rgn_srom1, rgn_srom2, rgn_alpha,
		rgn_color, rgn_remap, rgn_eeprom};

	// Graphics word completes on plane 7
	assign gfx_hit = accepted && (region_sel == rgn_gfx) && (load_addr.gfx.plane == 3'd7);
	// Program word completes on the odd byte
	assign rom_hit = accepted && ((prog_sel && load_addr.rom.lane) || byte_sel);

	// Word address per region size
	always_comb
	begin
		case (region_sel)
			rgn_rom0, rgn_slap:
				rom_addr_nx = `SYS1_PROG_AW'(load_addr.rom.word[13:0]);
			rgn_rom1, rgn_rom2, rgn_rom5, rgn_rom6, rgn_rom7:
				rom_addr_nx = load_addr.rom.word[14:0];
			rgn_srom0, rgn_srom1, rgn_srom2, rgn_alpha:
				rom_addr_nx = `SYS1_PROG_AW'(load_addr[`SYS1_BYTE_AW-1:0]);
			// 512 byte PROMs and EEPROM
			default:
				rom_addr_nx = `SYS1_PROG_AW'(load_addr[8:0]);
		endcase
	end

	// Strobes
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			gfx_we <= 1'b0;
			rom_we <= 1'b0;
		end
		else
		begin
			gfx_we <= gfx_hit;
			rom_we <= rom_hit;
		end
	end

	// Byte history and write payloads
	always_ff @(posedge clk_sys)
	begin
		if (accepted)
			acc_bytes <= {acc_bytes[47:0], load_data};
		if (gfx_hit)
		begin
			gfx_addr <= {load_addr.gfx.area, load_addr.gfx.bank, load_addr.gfx.offset};
			// Oldest byte ends up on top
			gfx_data <= {acc_bytes, load_data};
		end
		if (rom_hit)
		begin
			rom_region <= region_sel;
			rom_addr <= rom_addr_nx;
			rom_data <= prog_sel ? {acc_bytes[7:0], load_data} : {8'h00, load_data};
		end
	end

endmodule

// File: logic/sys1_pkg.sv
/*
 Types shared by the loader, the control mapper and the top level.
 Game numbers follow the slapstic type numbering of the board.
 Download addresses are always 25 bits wide.
*/
package sys1_pkg;

	// Destination of one download byte
	typedef enum logic [3:0] {
		rgn_none,
		rgn_gfx,
		rgn_rom0,
		rgn_rom1,
		rgn_rom2,
		rgn_rom5,
		rgn_rom6,
		rgn_rom7,
		rgn_slap,
		rgn_srom0,
		rgn_srom1,
		rgn_srom2,
		rgn_alpha,
		rgn_color,
		rgn_remap,
		rgn_eeprom
	} load_region_e;

	// Game variant, picks the control layout
	typedef enum logic [7:0] {
		game_marble = 8'd103,
		game_indy = 8'd105,
		game_peterpak = 8'd107,
		game_roadrunn = 8'd108,
		game_roadb109 = 8'd109,
		game_roadb110 = 8'd110
	} game_type_e;

	// One download address, two decodes
	typedef union packed {
		// Graphics store, 8 banks x 64K x 8 planes
		struct packed {
			logic [2:0] area;
			logic [2:0] bank;
			logic [15:0] offset;
			logic [2:0] plane;
		} gfx;
		// Program ROMs, byte pairs
		struct packed {
			logic [23:0] word;
			logic lane;
		} rom;
	} load_addr_u;

endpackage

// File: logic/sys1_defines.svh
/*
 Shared widths and match constants for the System-1 loader and controls.
 Region values are compared against the upper bits of the download
 address, so each one only makes sense at its own slice width.
 ROM3 has no entry; its image is loaded into the ROM7 slot.
*/
`ifndef SYS1_DEFINES_SVH
`define SYS1_DEFINES_SVH

// Address widths
`define SYS1_LOAD_AW 25
`define SYS1_GFX_AW 22
`define SYS1_PROG_AW 15
`define SYS1_BYTE_AW 14

// ####################
// Program regions, addr[24:15] or addr[24:16]
`define SYS1_RGN_ROM0 10'h080
`define SYS1_RGN_ROM1 9'h041
`define SYS1_RGN_ROM2 9'h042
`define SYS1_RGN_ROM5 9'h045
`define SYS1_RGN_ROM6 9'h046
// Also carries the ROM3 image for Indy
`define SYS1_RGN_ROM7 9'h047
`define SYS1_RGN_SLAP 10'h090

// Sound and alpha ROMs, addr[24:14]
`define SYS1_RGN_SROM0 11'h122
`define SYS1_RGN_SROM1 11'h123
`define SYS1_RGN_SROM2 11'h124
`define SYS1_RGN_ALPHA 11'h125

// PROMs and EEPROM image, addr[24:9]
`define SYS1_RGN_COLOR 16'h24C0
`define SYS1_RGN_REMAP 16'h24C1
`define SYS1_RGN_EEPROM 16'h24C2

// ####################
// ADC levels
`define SYS1_ADC_CENTER 8'h80
`define SYS1_ADC_FULL 8'hFF
`define SYS1_ADC_INV_SIGNED 8'h7F

// Indy is the power-up variant
`define SYS1_GAME_DEFAULT 8'd105

`endif
